// ==== filelist.f ====
rtl/fifoPkg.sv
rtl/pixelPkg.sv
rtl/ramIf.sv
rtl/resetSync.sv
rtl/grayPtrSync.sv
rtl/dualPortRam.sv
rtl/fifoWriteCtl.sv
rtl/fifoReadCtl.sv
rtl/pixelFifo.sv
test/clockGen.sv
test/pixelFifoTb.sv

// ==== Makefile ====
# Verilator build and run for the dual-clock pixel FIFO

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = pixelFifoTb
FILELIST = filelist.f

OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SOURCES  = $(wildcard rtl/*.sv) $(wildcard test/*.sv)
PASS_MSG = All tests passed!

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# pass only if the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== test/pixelFifoTb.sv ====
/*
 * Testbench for the dual-clock pixel FIFO
 *   two clocks, 20 ns source and 28 ns destination
 *   stimulus table applied step by step
 *   queue model of accepted pixels, latency and data monitors
 *   closing summary line
 */
`timescale 1ns/100ps
`default_nettype none

module pixelFifoTb;

    localparam int tbDepth    = 16;
    localparam int srcPeriod  = 20;
    localparam int dstPeriod  = 28;
    localparam int fillLimit  = tbDepth * 4;    // src cycles
    localparam int drainLimit = 2000;           // dst cycles
    localparam logic [31:0] rndSeed = 32'h9c34_a4a9;

    //------------------------------------------------------------
    // stimulus table
    //------------------------------------------------------------
    typedef enum logic [2:0] {opIdle, opWrite, opFill, opDrain, opRandom} opKind;

    typedef struct packed {
        opKind              kind;
        logic [15:0]        count;         // pulses, writes, extra writes or cycles
        logic               wrWhileFull;   // keep writing once full
        logic signed [15:0] expWords;      // words held or read back, -1 for any
    } stimStep;

    localparam stimStep stimTable [8] = '{
        '{opIdle,   16'd6,   1'b0, 16'sd0},
        '{opWrite,  16'd10,  1'b0, 16'sd10},
        '{opDrain,  16'd0,   1'b0, 16'sd10},
        '{opFill,   16'd5,   1'b1, 16'(tbDepth)},
        '{opDrain,  16'd0,   1'b0, 16'(tbDepth)},
        '{opWrite,  16'd3,   1'b0, 16'sd3},
        '{opRandom, 16'd300, 1'b0, -16'sd1},
        '{opDrain,  16'd0,   1'b0, -16'sd1}
    };

    logic              iSrcClk;
    logic              iDstClk;
    logic              rstN;
    logic              wrEn;
    pixelPkg::rgbPixel wrData;
    logic              rdEn;
    logic              full;
    pixelPkg::rgbPixel rdData;
    logic              rdValid;
    logic              empty;

    pixelPkg::rgbPixel pixelQueue [$];   // accepted, not yet read back
    int                errorCount;
    int                timeoutCount;
    int                writeCount;
    int                readCount;
    bit                monitorOn;
    logic [1:0]        acceptHist;       // [0] one dst edge ago, [1] two

    clockGen #(.pPeriod(srcPeriod)) srcClkGen_i (.clk(iSrcClk));
    clockGen #(.pPeriod(dstPeriod)) dstClkGen_i (.clk(iDstClk));

    pixelFifo #(.pDepth(tbDepth)) pixelFifo_i (
        .iSrcClk (iSrcClk),
        .iDstClk (iDstClk),
        .rstN    (rstN),
        .wrEn    (wrEn),
        .wrData  (wrData),
        .rdEn    (rdEn),
        .full    (full),
        .rdData  (rdData),
        .rdValid (rdValid),
        .empty   (empty)
    );

    function automatic pixelPkg::rgbPixel randomPixel();
        logic [31:0] rnd;
        rnd = $urandom;
        return rnd[23:0];    // red from bits 23:16
    endfunction

    //------------------------------------------------------------
    // monitors, sampled on the clock edge before the dut updates
    //------------------------------------------------------------
    always @(posedge iSrcClk)
    begin
        if (rstN === 1'b1 && wrEn === 1'b1 && full === 1'b0)
        begin
            pixelQueue.push_back(wrData);    // accepted write
            writeCount++;
        end
    end

    always @(posedge iDstClk)
    begin : dstMonitor
        logic              accepted;
        pixelPkg::rgbPixel expPixel;
        if (!monitorOn)
        begin
            acceptHist = 2'b00;
        end
        else
        begin
            accepted = (rdEn === 1'b1) && (empty === 1'b0);
            // valid two edges after the accepting edge
            assert (rdValid === acceptHist[1])
            else
            begin
                errorCount++;
                $display("[ERROR] rdValid got %h exp %h at %0t", rdValid, acceptHist[1], $time);
            end
            if (rdValid === 1'b1)
            begin
                readCount++;    // every valid word, matched or not
                if (pixelQueue.size() == 0)
                begin
                    errorCount++;
                    $display("rdValid came with no pixel left to read at %0t", $time);
                end
                else
                begin
                    expPixel = pixelQueue.pop_front();
                    assert (rdData === expPixel)
                    else
                    begin
                        errorCount++;
                        $display("[ERROR] rdData got %h exp %h", rdData, expPixel);
                    end
                end
            end
            acceptHist = {acceptHist[0], accepted};
        end
    end

    //------------------------------------------------------------
    // step tasks
    //------------------------------------------------------------
    task automatic checkIdleOutputs();
        assert (empty === 1'b1)
        else
        begin
            errorCount++;
            $display("[ERROR] empty got %h exp 1", empty);
        end
        assert (rdValid === 1'b0)
        else
        begin
            errorCount++;
            $display("[ERROR] rdValid got %h exp 0", rdValid);
        end
    endtask

    task automatic pulseReadsWhileEmpty(input int pulses);
        repeat (pulses)
        begin
            @(negedge iDstClk);
            rdEn = 1'b1;    // must be ignored
            checkIdleOutputs();
            @(negedge iDstClk);
            rdEn = 1'b0;
            checkIdleOutputs();
        end
    endtask

    task automatic writeBurst(input int words);
        repeat (words)
        begin
            @(negedge iSrcClk);
            wrEn   = 1'b1;
            wrData = randomPixel();
        end
        @(negedge iSrcClk);
        wrEn = 1'b0;
    endtask

    task automatic fillUntilFull(input int extraWrites, input bit wrWhileFull);
        int guard;
        guard = 0;
        repeat (4) @(negedge iSrcClk);    // let the read ptr settle in src
        while (full !== 1'b1 && guard < fillLimit)
        begin
            wrEn   = 1'b1;
            wrData = randomPixel();
            @(negedge iSrcClk);
            guard++;
        end
        if (full !== 1'b1)
        begin
            timeoutCount++;
            $display("timeout while filling, full never went high");
        end
        if (wrWhileFull)
        begin
            repeat (extraWrites)    // dropped by the dut
            begin
                wrEn   = 1'b1;
                wrData = randomPixel();
                @(negedge iSrcClk);
            end
        end
        wrEn = 1'b0;
        assert (full === 1'b1)
        else
        begin
            errorCount++;
            $display("[ERROR] full got %h exp 1", full);
        end
    endtask

    task automatic drainFifo(input int expWords);
        int startCount;
        int guard;
        startCount = readCount;
        guard      = 0;
        @(negedge iDstClk);
        rdEn = 1'b1;    // held high, back to back reads
        while (!(empty === 1'b1 && pixelQueue.size() == 0) && guard < drainLimit)
        begin
            @(negedge iDstClk);
            guard++;
        end
        rdEn = 1'b0;
        if (guard >= drainLimit)
        begin
            timeoutCount++;
            $display("timeout while draining, words still missing");
        end
        repeat (3) @(negedge iDstClk);    // catch any stray valid
        if (expWords >= 0)
        begin
            assert (readCount - startCount == expWords)
            else
            begin
                errorCount++;
                $display("[ERROR] words read got %h exp %h", readCount - startCount, expWords);
            end
        end
        checkIdleOutputs();
    endtask

    task automatic randomTraffic(input int srcCycles);
        bit writerDone;
        int guard;
        writerDone = 1'b0;
        guard      = 0;
        fork
            begin
                repeat (srcCycles)
                begin
                    @(negedge iSrcClk);
                    wrEn   = ($urandom % 2) == 1;
                    wrData = randomPixel();
                end
                @(negedge iSrcClk);
                wrEn       = 1'b0;
                writerDone = 1'b1;
            end
            begin
                while (!writerDone && guard < srcCycles * 2)
                begin
                    @(negedge iDstClk);
                    rdEn = ($urandom % 2) == 1;
                    guard++;
                end
                rdEn = 1'b0;
                if (!writerDone)
                begin
                    timeoutCount++;
                    $display("timeout in random traffic, writer did not finish");
                end
            end
        join
    endtask

    task automatic runStep(input stimStep step);
        case (step.kind)
            opIdle:   pulseReadsWhileEmpty(int'(step.count));
            opWrite:  writeBurst(int'(step.count));
            opFill:   fillUntilFull(int'(step.count), step.wrWhileFull);
            opDrain:  drainFifo(int'(step.expWords));
            opRandom: randomTraffic(int'(step.count));
            default:
            begin
                errorCount++;
                $display("unknown step kind in the stimulus table");
            end
        endcase
        if (step.kind == opWrite || step.kind == opFill)
        begin
            assert (pixelQueue.size() == int'(step.expWords))
            else
            begin
                errorCount++;
                $display("[ERROR] words held got %h exp %h", pixelQueue.size(), step.expWords);
            end
        end
    endtask

    //------------------------------------------------------------
    // main sequence
    //------------------------------------------------------------
    initial
    begin
        int guard;
        void'($urandom(rndSeed));
        rstN         = 1'b0;
        wrEn         = 1'b0;
        wrData       = '0;
        rdEn         = 1'b0;
        monitorOn    = 1'b0;
        errorCount   = 0;
        timeoutCount = 0;
        writeCount   = 0;
        readCount    = 0;
        guard        = 0;

        repeat (10) @(negedge iSrcClk);
        rstN = 1'b1;
        while (empty !== 1'b1 && guard < 20)    // dst side out of reset
        begin
            @(negedge iDstClk);
            guard++;
        end
        if (empty !== 1'b1)
        begin
            timeoutCount++;
            $display("timeout after reset, empty never went high");
        end
        @(negedge iDstClk);
        monitorOn = 1'b1;
        assert (full === 1'b0)
        else
        begin
            errorCount++;
            $display("[ERROR] full got %h exp 0", full);
        end
        checkIdleOutputs();

        for (int i = 0; i < $size(stimTable); i++)
        begin
            runStep(stimTable[i]);
        end

        $display("summary: %0d errors, %0d timeouts, %0d pixels written, %0d pixels read",
                 errorCount, timeoutCount, writeCount, readCount);
        if (errorCount == 0 && timeoutCount == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/clockGen.sv ====
/*
 * Free-running testbench clock
 * period set by pPeriod in ns, starts low
 */
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
    parameter int pPeriod = 20    // ns
)(
    output logic clk
);

    always
    begin
        clk = 1'b0;
        #(pPeriod / 2);
        clk = 1'b1;
        #(pPeriod - pPeriod / 2);    // odd periods still add up
    end

endmodule

`default_nettype wire

// ==== rtl/pixelFifo.sv ====
/*
 * Dual-clock pixel FIFO, top level
 *   source side   wrEn, wrData, full    on iSrcClk
 *   dest side     rdEn, rdData, rdValid, empty on iDstClk
 * rdData follows an accepted read by two destination cycles
 * pDepth must be a power of two
 */
`timescale 1ns/100ps
`default_nettype none

module pixelFifo #(
    parameter int pDepth = 16,                    // words, power of two
    parameter int pWidth = pixelPkg::pixelWidth   // ram word width
)(
    input  wire logic              iSrcClk,
    input  wire logic              iDstClk,
    input  wire logic              rstN,
    input  wire logic              wrEn,
    input  wire pixelPkg::rgbPixel wrData,
    input  wire logic              rdEn,
    output logic                   full,
    output pixelPkg::rgbPixel      rdData,
    output logic                   rdValid,
    output logic                   empty
);

    localparam int ptrBits = fifoPkg::addrWidth(pDepth) + 1;

    logic                             dstRstN;
    logic [pixelPkg::pixelWidth-1:0]  wrWord;          // flat pixel into the fifo
    logic [ptrBits-1:0]               wrPtrGray;       // iSrcClk
    logic [ptrBits-1:0]               wrPtrGraySync;   // iDstClk
    logic [ptrBits-1:0]               rdPtrGray;       // iDstClk
    logic [ptrBits-1:0]               rdPtrGraySync;   // iSrcClk

    ramIf #(.pDepth(pDepth), .pWidth(pWidth)) ramBus ();

    assign wrWord = wrData;
    assign rdData = pixelPkg::rgbPixel'(ramBus.rdData);

    //------------------------------------------------------------
    // reset into the destination domain
    //------------------------------------------------------------
    resetSync resetSync_i (
        .clk      (iDstClk),
        .rstN     (rstN),
        .syncRstN (dstRstN)
    );

    //------------------------------------------------------------
    // source domain
    //------------------------------------------------------------
    fifoWriteCtl #(.pDepth(pDepth)) fifoWriteCtl_i (
        .clk       (iSrcClk),
        .rstN      (rstN),
        .wrEn      (wrEn),
        .wrData    (wrWord),
        .rdPtrGray (rdPtrGraySync),
        .full      (full),
        .wrPtrGray (wrPtrGray),
        .ram       (ramBus.writer)
    );

    grayPtrSync #(.pPtrWidth(ptrBits)) rdPtrSync_i (   // read ptr into iSrcClk
        .clk      (iSrcClk),
        .rstN     (rstN),
        .grayIn   (rdPtrGray),
        .graySync (rdPtrGraySync)
    );

    //------------------------------------------------------------
    // destination domain
    //------------------------------------------------------------
    grayPtrSync #(.pPtrWidth(ptrBits)) wrPtrSync_i (   // write ptr into iDstClk
        .clk      (iDstClk),
        .rstN     (dstRstN),
        .grayIn   (wrPtrGray),
        .graySync (wrPtrGraySync)
    );

    fifoReadCtl #(.pDepth(pDepth)) fifoReadCtl_i (
        .clk       (iDstClk),
        .rstN      (dstRstN),
        .rdEn      (rdEn),
        .wrPtrGray (wrPtrGraySync),
        .empty     (empty),
        .rdValid   (rdValid),
        .rdPtrGray (rdPtrGray),
        .ram       (ramBus.reader)
    );

    // storage, written on src, read on dst
    dualPortRam #(.pDepth(pDepth), .pWidth(pWidth)) dualPortRam_i (
        .wrClk (iSrcClk),
        .rdClk (iDstClk),
        .ram   (ramBus.mem)
    );

endmodule

`default_nettype wire

// ==== rtl/fifoReadCtl.sv ====
/*
 * Destination-domain side of the pixel FIFO
 *   read pointer and its Gray copy
 *   registered empty flag
 *   two-stage valid pipeline matching the RAM read latency
 */
`timescale 1ns/100ps
`default_nettype none

module fifoReadCtl #(
    parameter int pDepth = 16
)(
    input  wire logic                                clk,
    input  wire logic                                rstN,
    input  wire logic                                rdEn,
    input  wire logic [fifoPkg::addrWidth(pDepth):0] wrPtrGray,   // already synced
    output logic                                     empty,
    output logic                                     rdValid,
    output logic      [fifoPkg::addrWidth(pDepth):0] rdPtrGray,
    ramIf.reader                                     ram
);

    localparam int addrBits = fifoPkg::addrWidth(pDepth);
    localparam int ptrBits  = addrBits + 1;

    logic               rdAccept;
    logic [ptrBits-1:0] rdPtr;
    logic [ptrBits-1:0] rdPtrNext;
    logic [ptrBits-1:0] wrPtrBin;      // synced write ptr in binary
    fifoPkg::ptrWord    wrBinWord;
    fifoPkg::ptrWord    rdGrayWord;
    logic [1:0]         validPipe;     // [0] ram addr taken, [1] ram data out
    logic [ptrBits-1:0] fillLevel;

    assign rdAccept   = rdEn & ~empty;   // reads while empty are ignored
    assign rdPtrNext  = rdPtr + ptrBits'(rdAccept);
    assign wrBinWord  = fifoPkg::gray2bin(fifoPkg::ptrWord'(wrPtrGray));
    assign wrPtrBin   = wrBinWord[ptrBits-1:0];
    assign rdGrayWord = fifoPkg::bin2gray(fifoPkg::ptrWord'(rdPtrNext));

    //------------------------------------------------------------
    // pointer, empty flag, valid pipeline
    //------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            rdPtr     <= '0;
            rdPtrGray <= '0;
            empty     <= 1'b1;
            validPipe <= 2'b00;
        end
        else
        begin
            rdPtr     <= rdPtrNext;
            rdPtrGray <= rdGrayWord[ptrBits-1:0];
            empty     <= (rdPtrNext == wrPtrBin);   // caught up with the writer
            validPipe <= {validPipe[0], rdAccept};  // t+1 -> t+2
        end
    end

    assign rdValid = validPipe[1];   // lines up with ram.rdData

    // ram read port, address registered inside the ram at edge t
    assign ram.rdEn   = rdAccept;
    assign ram.rdAddr = rdPtr[addrBits-1:0];

    //------------------------------------------------------------
    // reader never runs ahead of the synced writer
    //------------------------------------------------------------
    assign fillLevel = wrPtrBin - rdPtr;

    aNoUnderrun: assert property (@(posedge clk) disable iff (!rstN)
        fillLevel <= ptrBits'(pDepth));

endmodule

`default_nettype wire

// ==== rtl/fifoWriteCtl.sv ====
/*
 * Source-domain side of the pixel FIFO
 *   binary write pointer and its Gray copy
 *   registered full flag, inverted top two Gray bits
 *   RAM write port
 */
`timescale 1ns/100ps
`default_nettype none

module fifoWriteCtl #(
    parameter int pDepth = 16
)(
    input  wire logic                            clk,
    input  wire logic                            rstN,
    input  wire logic                            wrEn,
    input  wire logic [pixelPkg::pixelWidth-1:0] wrData,
    input  wire logic [fifoPkg::addrWidth(pDepth):0] rdPtrGray,   // already synced
    output logic                                 full,
    output logic      [fifoPkg::addrWidth(pDepth):0] wrPtrGray,
    ramIf.writer                                 ram
);

    localparam int addrBits = fifoPkg::addrWidth(pDepth);
    localparam int ptrBits  = addrBits + 1;

    logic                 wrAccept;
    logic [ptrBits-1:0]   wrPtr;
    logic [ptrBits-1:0]   wrPtrNext;
    logic [ptrBits-1:0]   rdGrayFull;    // read ptr as it looks one lap behind
    fifoPkg::ptrWord      wrGrayWord;
    fifoPkg::ptrWord      rdBinWord;
    logic [ptrBits-1:0]   fillLevel;

    assign wrAccept  = wrEn & ~full;   // writes while full are dropped
    assign wrPtrNext = wrPtr + ptrBits'(wrAccept);
    assign wrGrayWord = fifoPkg::bin2gray(fifoPkg::ptrWord'(wrPtrNext));
    assign rdGrayFull = rdPtrGray ^ (ptrBits'(3) << (ptrBits - 2));  // flip top two

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            wrPtr     <= '0;
            wrPtrGray <= '0;
            full      <= 1'b0;
        end
        else
        begin
            wrPtr     <= wrPtrNext;
            wrPtrGray <= wrGrayWord[ptrBits-1:0];   // registered, glitch free crossing
            full      <= (wrGrayWord[ptrBits-1:0] == rdGrayFull);
        end
    end

    // ram write port
    assign ram.wrEn   = wrAccept;
    assign ram.wrAddr = wrPtr[addrBits-1:0];
    assign ram.wrData = wrData;

    //------------------------------------------------------------
    // no write may land on a fifo that already holds pDepth words
    //------------------------------------------------------------
    assign rdBinWord = fifoPkg::gray2bin(fifoPkg::ptrWord'(rdPtrGray));
    assign fillLevel = wrPtr - rdBinWord[ptrBits-1:0];   // pessimistic, read ptr lags

    aNoOverflow: assert property (@(posedge clk) disable iff (!rstN)
        ram.wrEn |-> (fillLevel < ptrBits'(pDepth)));

endmodule

`default_nettype wire

// ==== rtl/dualPortRam.sv ====
/*
 * Simple dual-port pixel memory
 *   write port on wrClk
 *   read address sampled on rdClk with rdEn,
 *   data registered on the following rdClk edge
 */
`timescale 1ns/100ps
`default_nettype none

module dualPortRam #(
    parameter int pDepth = 16,
    parameter int pWidth = pixelPkg::pixelWidth
)(
    input wire logic wrClk,
    input wire logic rdClk,
    ramIf.mem        ram
);

    localparam int addrBits = fifoPkg::addrWidth(pDepth);

    logic [pWidth-1:0]   memArray [pDepth];   // pixel storage
    logic [addrBits-1:0] rdAddrQ;             // read address register

    //------------------------------------------------------------
    // write side
    //------------------------------------------------------------
    always_ff @(posedge wrClk)
    begin
        if (ram.wrEn)
        begin
            memArray[ram.wrAddr] <= ram.wrData;   // stored on the accepting edge
        end
    end

    //------------------------------------------------------------
    // read side, two registers deep
    //------------------------------------------------------------
    always_ff @(posedge rdClk)
    begin
        if (ram.rdEn)
        begin
            rdAddrQ <= ram.rdAddr;   // edge t
        end
        ram.rdData <= memArray[rdAddrQ];   // edge t+1, old address
    end

endmodule

`default_nettype wire

// ==== rtl/grayPtrSync.sv ====
/*
 * Two-flop synchronizer for a Gray-coded FIFO pointer
 * checks that the pointer only moves forward,
 * by at most one full fifo per clk
 */
`timescale 1ns/100ps
`default_nettype none

module grayPtrSync #(
    parameter int pPtrWidth = 5
)(
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic [pPtrWidth-1:0] grayIn,
    output logic      [pPtrWidth-1:0] graySync
);

    localparam logic [pPtrWidth-1:0] maxStep = 1 << (pPtrWidth - 1);  // one full fifo

    logic [pPtrWidth-1:0] meta;        // first stage, grayIn one clk ago
    fifoPkg::ptrWord      inBinWord;
    fifoPkg::ptrWord      metaBinWord;
    logic [pPtrWidth-1:0] step;        // positions moved since last clk

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            meta     <= '0;
            graySync <= '0;
        end
        else
        begin
            meta     <= grayIn;
            graySync <= meta;
        end
    end

    //------------------------------------------------------------
    // gray crossing checks
    //------------------------------------------------------------
    assign inBinWord   = fifoPkg::gray2bin(fifoPkg::ptrWord'(grayIn));
    assign metaBinWord = fifoPkg::gray2bin(fifoPkg::ptrWord'(meta));
    assign step        = inBinWord[pPtrWidth-1:0] - metaBinWord[pPtrWidth-1:0];

    // a faster source may take several steps, but never backwards
    aForward: assert property (@(posedge clk) disable iff (!rstN)
        step <= maxStep);

endmodule

`default_nettype wire

// ==== rtl/resetSync.sv ====
/*
 * Reset synchronizer for the destination domain
 * rstN is shifted through two flops, so release is clean on clk
 */
`timescale 1ns/100ps
`default_nettype none

module resetSync (
    input  wire logic clk,
    input  wire logic rstN,
    output logic      syncRstN
);

    logic [1:0] rstPipe;    // [0] may go metastable, [1] is clean

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            rstPipe <= 2'b00;
        end
        else
        begin
            rstPipe <= {rstPipe[0], 1'b1};    // ones shift in after release
        end
    end

    assign syncRstN = rstPipe[1];

endmodule

`default_nettype wire

// ==== rtl/ramIf.sv ====
/*
 * RAM port bundle for the pixel FIFO
 *   write side   wrEn, wrAddr, wrData
 *   read side    rdEn, rdAddr, rdData
 * modports for writer, reader and the memory itself
 */
`timescale 1ns/100ps
`default_nettype none

interface ramIf #(
    parameter int pDepth = 16,
    parameter int pWidth = pixelPkg::pixelWidth
);

    localparam int addrBits = fifoPkg::addrWidth(pDepth);

    logic                wrEn;     // write strobe, already gated by full
    logic [addrBits-1:0] wrAddr;
    logic [pWidth-1:0]   wrData;
    logic                rdEn;     // accepted read, gated by empty
    logic [addrBits-1:0] rdAddr;
    logic [pWidth-1:0]   rdData;   // registered ram output

    modport writer (output wrEn, wrAddr, wrData);
    modport reader (output rdEn, rdAddr, input rdData);
    modport mem    (input wrEn, wrAddr, wrData, rdEn, rdAddr, output rdData);

endinterface

`default_nettype wire

// ==== rtl/pixelPkg.sv ====
/*
 * Pixel format
 *   channelWidth, pixelWidth
 *   rgbPixel, 8 bits per channel, red in the top byte
 */
`default_nettype none

package pixelPkg;

    localparam int channelWidth = 8;
    localparam int pixelWidth   = 3 * channelWidth;    // 24 bit RGB word

    // red is the msb byte, blue the lsb byte
    typedef struct packed {
        logic [channelWidth-1:0] red;
        logic [channelWidth-1:0] green;
        logic [channelWidth-1:0] blue;
    } rgbPixel;

endpackage

`default_nettype wire

// ==== rtl/fifoPkg.sv ====
/*
 * Pointer arithmetic for the dual-clock FIFO
 *   addrWidth  address bits for a given depth
 *   bin2gray   binary to Gray code
 *   gray2bin   Gray code back to binary
 * Pointers are one bit wider than the address, so full and empty differ
 */
`default_nettype none

package fifoPkg;

    localparam int ptrMaxWidth = 32;        // widest pointer the helpers handle

    typedef logic [ptrMaxWidth-1:0] ptrWord;

    // ------------------------------------------------------------
    // ceil(log2(depth)), never below one bit
    function automatic int addrWidth(input int depth);
        int width;
        width = 1;
        while ((1 << width) < depth)
        begin
            width++;
        end
        return width;
    endfunction

    // only one bit flips between neighbours
    function automatic ptrWord bin2gray(input ptrWord bin);
        return bin ^ (bin >> 1);
    endfunction

    // each binary bit is the xor of all gray bits above and at it
    function automatic ptrWord gray2bin(input ptrWord gray);
        ptrWord bin;
        bin[ptrMaxWidth-1] = gray[ptrMaxWidth-1];
        for (int i = ptrMaxWidth - 2; i >= 0; i--)
        begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

`default_nettype wire
